// File: source/rnd_pkg.sv
// single precision only; exponent carries 2 guard bits so overflow past 255 stays visible
`default_nettype none

package rnd_pkg;

  //////////////////////////////////////////////////////////////////////
  // format constants
  //////////////////////////////////////////////////////////////////////

  // stored mantissa bits, hidden bit excluded
  localparam int unsigned MAN_W   = 23;
  // internal exponent, room for a carry beyond 255
  localparam int unsigned EXP_W   = 10;
  // hidden, mantissa, round, sticky
  localparam int unsigned FRACT_W = MAN_W + 3;

  // largest finite biased exponent
  localparam logic [EXP_W-1:0] EXP_MAX = 10'd254;

  // special magnitudes, sign bit added by the user
  localparam logic [30:0] INF_S  = {8'hff, 23'd0};
  localparam logic [30:0] QNAN_S = {8'hff, 1'b1, 22'd0};
  localparam logic [30:0] SNAN_S = {8'hff, 1'b0, {22{1'b1}}};

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RND_NEAREST,
    RND_ZERO,
    RND_UP,
    RND_DOWN
  } rnd_mode_e;

  // one producer operand, fraction already pre-normalized
  typedef struct packed {
    logic               sign;
    logic [EXP_W-1:0]   exp;
    logic [5:0]         shr;
    logic [FRACT_W-1:0] fract;
  } rnd_src_t;

  // special cases from order control
  typedef struct packed {
    logic inv;
    logic inf;
    logic snan;
    logic qnan;
    logic anan_sign;
  } rnd_spec_t;

  // exception flags, same order as the status register
  typedef struct packed {
    logic ovf;
    logic unf;
    logic snan;
    logic qnan;
    logic zer;
    logic ine;
    logic inv;
    logic inf;
  } rnd_flags_t;

  typedef struct packed {
    rnd_src_t  src;
    rnd_spec_t spec;
  } rnd_s0_t;

  // aligned value, hidden bit at the top of man
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W:0]   man;
    logic             rbit;
    logic             sticky;
    rnd_spec_t        spec;
  } rnd_s1_t;

  // rounded and classified value
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W:0]   man;
    logic             lost;
    logic             ovf;
    logic             dn;
    rnd_spec_t        spec;
  } rnd_s3_t;

endpackage

`default_nettype wire

// File: source/rnd_capture.sv
// adder and multiplier ready must never be high together; operand held until taking is seen
`default_nettype none

module rnd_capture (
  input  logic               cpu_clk,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               add_rdy_i,
  input  rnd_pkg::rnd_src_t  add_src_i,
  input  logic               add_sub_zero_i,
  input  logic               mul_rdy_i,
  input  rnd_pkg::rnd_src_t  mul_src_i,
  input  rnd_pkg::rnd_spec_t spec_i,
  input  rnd_pkg::rnd_mode_e rm_i,
  input  logic               busy_i,
  output logic               add_taking_o,
  output logic               mul_taking_o,
  output rnd_pkg::rnd_s0_t   s0_o,
  output logic               ready_o,
  output logic               busy_o
);

  logic              s0_adv;
  logic              s1_adv;
  rnd_pkg::rnd_src_t src_sel;

  // busy chain, stage 0 part
  assign busy_o = ready_o & busy_i;
  assign s0_adv = (add_rdy_i | mul_rdy_i) & ~busy_o;
  assign s1_adv = ready_o & ~busy_i;

  // producer strobes
  assign add_taking_o = add_rdy_i & ~busy_o;
  assign mul_taking_o = mul_rdy_i & ~busy_o;

  // operand mux
  always_comb begin
    src_sel = add_rdy_i ? add_src_i : mul_src_i;
    // exact zero of a subtraction: -0 only when rounding down
    if (add_rdy_i && add_sub_zero_i) begin
      src_sel.sign = (rm_i == rnd_pkg::RND_DOWN);
    end
  end

  // stage 0 payload
  always_ff @(posedge cpu_clk) begin
    if (s0_adv) begin
      s0_o.src  <= src_sel;
      s0_o.spec <= spec_i;
    end
  end

  // stage 0 ready
  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_o <= 1'b0;
    end else if (flush_i) begin
      ready_o <= 1'b0;
    end else if (s0_adv) begin
      ready_o <= 1'b1;
    end else if (s1_adv) begin
      ready_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/rnd_align.sv
// right shift only; shift amounts past the fraction width fold the whole fraction into sticky
`default_nettype none

module rnd_align (
  input  logic             cpu_clk,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  rnd_pkg::rnd_s0_t s0_i,
  input  logic             ready_i,
  input  logic             busy_i,
  output rnd_pkg::rnd_s1_t s1_o,
  output logic             ready_o,
  output logic             busy_o
);

  logic                        s1_adv;
  logic                        s2_adv;
  logic [rnd_pkg::FRACT_W-1:0] fract_shr;
  logic                        sticky;

  // busy chain, stage 1 part
  assign busy_o = ready_o & busy_i;
  assign s1_adv = ready_i & ~busy_o;
  assign s2_adv = ready_o & ~busy_i;

  // align
  assign fract_shr = s0_i.src.fract >> s0_i.src.shr;

  // sticky: old sticky plus every bit that lands below the round position
  always_comb begin
    sticky = s0_i.src.fract[0];
    for (int i = 1; i < rnd_pkg::FRACT_W; i++) begin
      if (i <= s0_i.src.shr) begin
        sticky = sticky | s0_i.src.fract[i];
      end
    end
  end

  // stage 1 payload
  always_ff @(posedge cpu_clk) begin
    if (s1_adv) begin
      s1_o.sign   <= s0_i.src.sign;
      s1_o.exp    <= s0_i.src.exp;
      s1_o.man    <= fract_shr[rnd_pkg::FRACT_W-1:2];
      s1_o.rbit   <= fract_shr[1];
      s1_o.sticky <= sticky;
      s1_o.spec   <= s0_i.spec;
    end
  end

  // stage 1 ready
  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_o <= 1'b0;
    end else if (flush_i) begin
      ready_o <= 1'b0;
    end else if (s1_adv) begin
      ready_o <= 1'b1;
    end else if (s2_adv) begin
      ready_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/rnd_round.sv
// rm_i is sampled in stage 2; a denormal that rounds into the hidden bit keeps its exponent
`default_nettype none

module rnd_round (
  input  logic               cpu_clk,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  rnd_pkg::rnd_s1_t   s1_i,
  input  logic               ready_i,
  input  rnd_pkg::rnd_mode_e rm_i,
  input  logic               hold_i,
  output rnd_pkg::rnd_s3_t   s3_o,
  output logic               ready_o,
  output logic               busy_o
);

  // stage 2 keeps the carry bit of the increment
  typedef struct packed {
    logic                      sign;
    logic [rnd_pkg::EXP_W-1:0] exp;
    logic [rnd_pkg::MAN_W+1:0] man_rnd;
    logic                      lost;
    rnd_pkg::rnd_spec_t        spec;
  } s2_t;

  s2_t                       s2_r;
  logic                      s2_ready;
  logic                      s2_adv;
  logic                      s3_adv;
  logic                      s3_busy;
  logic                      lost;
  logic                      rnd_up;
  logic                      carry;
  logic [rnd_pkg::EXP_W-1:0] exp_c;
  logic [rnd_pkg::MAN_W:0]   man_c;

  // busy chain, stages 2 and 3
  assign s3_busy = ready_o & hold_i;
  assign busy_o  = s2_ready & s3_busy;
  assign s2_adv  = ready_i & ~busy_o;
  assign s3_adv  = s2_ready & ~s3_busy;

  //////////////////////////////////////////////////////////////////////
  // stage 2: round increment
  //////////////////////////////////////////////////////////////////////

  assign lost = s1_i.rbit | s1_i.sticky;

  always_comb begin
    case (rm_i)
      // ties go to even
      rnd_pkg::RND_NEAREST: rnd_up = s1_i.rbit & (s1_i.sticky | s1_i.man[0]);
      rnd_pkg::RND_UP:      rnd_up = ~s1_i.sign & lost;
      rnd_pkg::RND_DOWN:    rnd_up = s1_i.sign & lost;
      default:              rnd_up = 1'b0;
    endcase
  end

  always_ff @(posedge cpu_clk) begin
    if (s2_adv) begin
      s2_r.sign    <= s1_i.sign;
      s2_r.exp     <= s1_i.exp;
      s2_r.man_rnd <= {1'b0, s1_i.man} + {{(rnd_pkg::MAN_W + 1){1'b0}}, rnd_up};
      s2_r.lost    <= lost;
      s2_r.spec    <= s1_i.spec;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 3: carry renormalize and classify
  //////////////////////////////////////////////////////////////////////

  assign carry = s2_r.man_rnd[rnd_pkg::MAN_W+1];
  assign exp_c = s2_r.exp + {{(rnd_pkg::EXP_W - 1){1'b0}}, carry};
  assign man_c = carry ? s2_r.man_rnd[rnd_pkg::MAN_W+1:1] : s2_r.man_rnd[rnd_pkg::MAN_W:0];

  always_ff @(posedge cpu_clk) begin
    if (s3_adv) begin
      s3_o.sign <= s2_r.sign;
      s3_o.exp  <= exp_c;
      s3_o.man  <= man_c;
      s3_o.lost <= s2_r.lost;
      s3_o.ovf  <= (exp_c > rnd_pkg::EXP_MAX) | s2_r.spec.inf;
      // hidden bit clear: denormal or zero
      s3_o.dn   <= ~man_c[rnd_pkg::MAN_W];
      s3_o.spec <= s2_r.spec;
    end
  end

  // ready flags; stage 3 empties unless the write-back side holds
  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s2_ready <= 1'b0;
      ready_o  <= 1'b0;
    end else if (flush_i) begin
      s2_ready <= 1'b0;
      ready_o  <= 1'b0;
    end else begin
      if (s2_adv) begin
        s2_ready <= 1'b1;
      end else if (s3_adv) begin
        s2_ready <= 1'b0;
      end
      if (s3_adv) begin
        ready_o <= 1'b1;
      end else if (!hold_i) begin
        ready_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rnd_wrbk.sv
// mask_i applies when a result is formatted; a result caught in the miss buffer keeps its flags
`default_nettype none

module rnd_wrbk (
  input  logic                cpu_clk,
  input  logic                rst_n_i,
  input  logic                flush_i,
  input  rnd_pkg::rnd_s3_t    s3_i,
  input  logic                ready_i,
  input  rnd_pkg::rnd_flags_t mask_i,
  input  logic                except_en_i,
  input  logic                padv_wrbk_i,
  input  logic                grant_i,
  output logic                hold_o,
  output logic                valid_o,
  output logic                exec_except_o,
  output logic [31:0]         res_o,
  output rnd_pkg::rnd_flags_t flags_o,
  output logic                flags_we_o,
  output logic                wrbk_except_o
);

  logic [31:0]         res_fmt;
  rnd_pkg::rnd_flags_t flags_raw;
  rnd_pkg::rnd_flags_t flags_fmt;
  logic [31:0]         buf_res;
  rnd_pkg::rnd_flags_t buf_flags;
  logic [31:0]         res_m;
  rnd_pkg::rnd_flags_t flags_m;
  logic                except_m;
  logic                wrbk_go;

  //////////////////////////////////////////////////////////////////////
  // result formatting, by priority
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    flags_raw = '0;
    if (s3_i.spec.qnan || s3_i.spec.snan) begin
      // NaN operand in, quiet NaN out
      res_fmt = {s3_i.spec.anan_sign, rnd_pkg::QNAN_S};
    end else if (s3_i.spec.inv) begin
      res_fmt = {s3_i.sign, rnd_pkg::SNAN_S};
    end else if (s3_i.ovf) begin
      res_fmt       = {s3_i.sign, rnd_pkg::INF_S};
      flags_raw.inf = 1'b1;
      // an infinite operand is exact, no overflow
      flags_raw.ovf = ~s3_i.spec.inf;
      flags_raw.ine = ~s3_i.spec.inf;
    end else if (s3_i.dn) begin
      res_fmt       = {s3_i.sign, 8'd0, s3_i.man[rnd_pkg::MAN_W-1:0]};
      flags_raw.ine = s3_i.lost;
      flags_raw.unf = s3_i.lost;
      flags_raw.zer = ~|s3_i.man;
    end else begin
      res_fmt       = {s3_i.sign, s3_i.exp[7:0], s3_i.man[rnd_pkg::MAN_W-1:0]};
      flags_raw.ine = s3_i.lost;
    end
    // flags straight from order control
    flags_raw.snan = s3_i.spec.inv | s3_i.spec.snan;
    flags_raw.qnan = s3_i.spec.qnan;
    flags_raw.inv  = s3_i.spec.inv;
  end

  assign flags_fmt = rnd_pkg::rnd_flags_t'(flags_raw & mask_i);

  //////////////////////////////////////////////////////////////////////
  // miss buffer
  //////////////////////////////////////////////////////////////////////

  // a result waits at stage 3 or in the buffer
  assign valid_o = ready_i | hold_o;
  assign wrbk_go = padv_wrbk_i & grant_i & valid_o;

  // hold rises when stage 3 is not taken, falls on write-back
  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_o <= 1'b0;
    end else if (flush_i || wrbk_go) begin
      hold_o <= 1'b0;
    end else if (!hold_o) begin
      hold_o <= ready_i;
    end
  end

  // buffer tracks stage 3 until hold is set
  always_ff @(posedge cpu_clk) begin
    if (!hold_o) begin
      buf_res   <= res_fmt;
      buf_flags <= flags_fmt;
    end
  end

  // oldest result first
  assign res_m   = hold_o ? buf_res : res_fmt;
  assign flags_m = hold_o ? buf_flags : flags_fmt;

  //////////////////////////////////////////////////////////////////////
  // write-back
  //////////////////////////////////////////////////////////////////////

  assign except_m      = except_en_i & (|flags_m);
  assign exec_except_o = grant_i & except_m;

  // cleared on a write-back cycle owned by another unit
  always_ff @(posedge cpu_clk) begin
    if (padv_wrbk_i) begin
      res_o <= wrbk_go ? res_m : 32'd0;
    end
    if (wrbk_go) begin
      flags_o <= flags_m;
    end
  end

  // one-cycle strobes
  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flags_we_o    <= 1'b0;
      wrbk_except_o <= 1'b0;
    end else if (flush_i) begin
      flags_we_o    <= 1'b0;
      wrbk_except_o <= 1'b0;
    end else begin
      flags_we_o    <= wrbk_go;
      wrbk_except_o <= wrbk_go & except_m;
    end
  end

endmodule

`default_nettype wire

// File: source/rnd_top.sv
// four-stage rounding pipe plus one miss buffer; up to five results in flight, no reordering
`default_nettype none

module rnd_top (
  input  logic                cpu_clk,
  input  logic                rst_n_i,
  input  logic                pipeline_flush_i,
  // producers
  input  logic                add_rdy_i,
  input  rnd_pkg::rnd_src_t   add_src_i,
  input  logic                add_sub_zero_i,
  input  logic                mul_rdy_i,
  input  rnd_pkg::rnd_src_t   mul_src_i,
  output logic                add_taking_o,
  output logic                mul_taking_o,
  // control levels
  input  rnd_pkg::rnd_spec_t  spec_i,
  input  rnd_pkg::rnd_mode_e  rm_i,
  input  rnd_pkg::rnd_flags_t mask_i,
  input  logic                except_en_i,
  // write-back
  input  logic                padv_wrbk_i,
  input  logic                grant_i,
  output logic                valid_o,
  output logic                exec_except_o,
  output logic [31:0]         res_o,
  output rnd_pkg::rnd_flags_t flags_o,
  output logic                flags_we_o,
  output logic                wrbk_except_o
);

  rnd_pkg::rnd_s0_t s0;
  rnd_pkg::rnd_s1_t s1;
  rnd_pkg::rnd_s3_t s3;
  logic             s0_ready;
  logic             s1_ready;
  logic             s3_ready;
  logic             s1_busy;
  logic             s2_busy;
  logic             hold;

  // stage 0 busy reaches the producers through the taking strobes
  rnd_capture rnd_capture_i (
    .cpu_clk        (cpu_clk),
    .rst_n_i        (rst_n_i),
    .flush_i        (pipeline_flush_i),
    .add_rdy_i      (add_rdy_i),
    .add_src_i      (add_src_i),
    .add_sub_zero_i (add_sub_zero_i),
    .mul_rdy_i      (mul_rdy_i),
    .mul_src_i      (mul_src_i),
    .spec_i         (spec_i),
    .rm_i           (rm_i),
    .busy_i         (s1_busy),
    .add_taking_o   (add_taking_o),
    .mul_taking_o   (mul_taking_o),
    .s0_o           (s0),
    .ready_o        (s0_ready),
    .busy_o         ()
  );

  rnd_align rnd_align_i (
    .cpu_clk (cpu_clk),
    .rst_n_i (rst_n_i),
    .flush_i (pipeline_flush_i),
    .s0_i    (s0),
    .ready_i (s0_ready),
    .busy_i  (s2_busy),
    .s1_o    (s1),
    .ready_o (s1_ready),
    .busy_o  (s1_busy)
  );

  rnd_round rnd_round_i (
    .cpu_clk (cpu_clk),
    .rst_n_i (rst_n_i),
    .flush_i (pipeline_flush_i),
    .s1_i    (s1),
    .ready_i (s1_ready),
    .rm_i    (rm_i),
    .hold_i  (hold),
    .s3_o    (s3),
    .ready_o (s3_ready),
    .busy_o  (s2_busy)
  );

  rnd_wrbk rnd_wrbk_i (
    .cpu_clk       (cpu_clk),
    .rst_n_i       (rst_n_i),
    .flush_i       (pipeline_flush_i),
    .s3_i          (s3),
    .ready_i       (s3_ready),
    .mask_i        (mask_i),
    .except_en_i   (except_en_i),
    .padv_wrbk_i   (padv_wrbk_i),
    .grant_i       (grant_i),
    .hold_o        (hold),
    .valid_o       (valid_o),
    .exec_except_o (exec_except_o),
    .res_o         (res_o),
    .flags_o       (flags_o),
    .flags_we_o    (flags_we_o),
    .wrbk_except_o (wrbk_except_o)
  );

endmodule

`default_nettype wire

// File: dv/rnd_model.svh
// included inside rnd_tb only; one shared xorshift state, so call order fixes the random sequence
`ifndef RND_MODEL_SVH
`define RND_MODEL_SVH

// expected write-back for one operand
typedef struct packed {
  logic [31:0]         res;
  rnd_pkg::rnd_flags_t flags;
} expect_t;

// xorshift32 state, fixed seed
logic [31:0] rng_state = 32'h638e;

function automatic logic [31:0] rand_next();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// reference: align, round, classify, format, mask
function automatic expect_t model_result(input rnd_pkg::rnd_src_t   src,
                                         input logic                sub_zero,
                                         input rnd_pkg::rnd_spec_t  spec,
                                         input rnd_pkg::rnd_mode_e  rm,
                                         input rnd_pkg::rnd_flags_t mask);
  expect_t             r;
  rnd_pkg::rnd_flags_t f;
  logic                sign;
  logic [9:0]          exp;
  logic [25:0]         shifted;
  logic [63:0]         low;
  logic                sticky;
  logic                lost;
  logic                up;
  logic [24:0]         sum;
  logic [23:0]         man;
  logic                ovf;
  // exact zero of a subtraction takes its sign from the mode
  sign    = sub_zero ? (rm == rnd_pkg::RND_DOWN) : src.sign;
  shifted = src.fract >> src.shr;
  // bits 0..shr of the input end up at or below the sticky slot
  low     = (64'd1 << (src.shr + 7'd1)) - 64'd1;
  sticky  = |(src.fract & low[25:0]);
  lost    = shifted[1] | sticky;
  case (rm)
    rnd_pkg::RND_NEAREST: up = shifted[1] & (sticky | shifted[2]);
    rnd_pkg::RND_UP:      up = !sign && lost;
    rnd_pkg::RND_DOWN:    up = sign && lost;
    default:              up = 1'b0;
  endcase
  sum = {1'b0, shifted[25:2]} + 25'(up);
  exp = src.exp;
  if (sum[24]) begin
    // carry out, renormalize
    man = sum[24:1];
    exp = exp + 10'd1;
  end else begin
    man = sum[23:0];
  end
  ovf    = (exp > 10'd254) || spec.inf;
  f      = '0;
  f.snan = spec.inv | spec.snan;
  f.qnan = spec.qnan;
  f.inv  = spec.inv;
  if (spec.qnan || spec.snan) begin
    r.res = {spec.anan_sign, 8'hff, 1'b1, 22'd0};
  end else if (spec.inv) begin
    r.res = {sign, 8'hff, 1'b0, {22{1'b1}}};
  end else if (ovf) begin
    r.res = {sign, 8'hff, 23'd0};
    f.inf = 1'b1;
    f.ovf = !spec.inf;
    f.ine = !spec.inf;
  end else if (!man[23]) begin
    r.res = {sign, 8'd0, man[22:0]};
    f.ine = lost;
    f.unf = lost;
    f.zer = (man == 24'd0);
  end else begin
    r.res = {sign, exp[7:0], man[22:0]};
    f.ine = lost;
  end
  r.flags = rnd_pkg::rnd_flags_t'(f & mask);
  return r;
endfunction

`endif

// File: dv/rnd_tb.sv
// mode, mask and except_en only change with the pipe drained; padv_wrbk_i drops only in grant stretches
`default_nettype none

module rnd_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int N_RAND     = 40;
  localparam int N_SMALL    = 8;
  localparam int N_STALL    = 60;
  // per-test operand counts, for the watchdog
  localparam int TOTAL_OPS  = 4 * (N_RAND + 1) + 2 * N_SMALL + 4 * (N_SMALL + 1)
                            + 2 * N_SMALL + N_STALL + 3 + N_SMALL;
  localparam int MAX_CYCLES = 20 * TOTAL_OPS + 200;

  logic                cpu_clk;
  logic                rst_n_i;
  logic                pipeline_flush_i;
  logic                add_rdy_i;
  rnd_pkg::rnd_src_t   add_src_i;
  logic                add_sub_zero_i;
  logic                mul_rdy_i;
  rnd_pkg::rnd_src_t   mul_src_i;
  logic                add_taking_o;
  logic                mul_taking_o;
  rnd_pkg::rnd_spec_t  spec_i;
  rnd_pkg::rnd_mode_e  rm_i;
  rnd_pkg::rnd_flags_t mask_i;
  logic                except_en_i;
  logic                padv_wrbk_i;
  logic                grant_i;
  logic                valid_o;
  logic                exec_except_o;
  logic [31:0]         res_o;
  rnd_pkg::rnd_flags_t flags_o;
  logic                flags_we_o;
  logic                wrbk_except_o;

  `include "rnd_model.svh"

  // scoreboard
  expect_t exp_q[$];
  int      errors       = 0;
  int      checks       = 0;
  int      accept_cnt   = 0;
  int      issue_mark   = 0;
  int      stretch      = 0;
  logic    grant_random = 1'b0;
  string   test_name    = "reset";

  initial begin
    cpu_clk = 1'b0;
    forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
  end

  rnd_top rnd_top_i (
    .cpu_clk          (cpu_clk),
    .rst_n_i          (rst_n_i),
    .pipeline_flush_i (pipeline_flush_i),
    .add_rdy_i        (add_rdy_i),
    .add_src_i        (add_src_i),
    .add_sub_zero_i   (add_sub_zero_i),
    .mul_rdy_i        (mul_rdy_i),
    .mul_src_i        (mul_src_i),
    .add_taking_o     (add_taking_o),
    .mul_taking_o     (mul_taking_o),
    .spec_i           (spec_i),
    .rm_i             (rm_i),
    .mask_i           (mask_i),
    .except_en_i      (except_en_i),
    .padv_wrbk_i      (padv_wrbk_i),
    .grant_i          (grant_i),
    .valid_o          (valid_o),
    .exec_except_o    (exec_except_o),
    .res_o            (res_o),
    .flags_o          (flags_o),
    .flags_we_o       (flags_we_o),
    .wrbk_except_o    (wrbk_except_o)
  );

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // one clock, falling edge; grant and write-back slot stretches are drawn here
  task automatic next_cycle();
    logic [31:0] r;
    @(negedge cpu_clk);
    if (grant_random) begin
      if (stretch == 0) begin
        r           = rand_next();
        grant_i     = r[0];
        padv_wrbk_i = |r[6:5];
        stretch     = int'(r[4:1]);
      end else begin
        stretch--;
      end
    end
  endtask

  // normal operand, hidden bit set, some right shifts
  function automatic rnd_pkg::rnd_src_t rand_src();
    rnd_pkg::rnd_src_t s;
    logic [31:0]       a;
    logic [31:0]       b;
    a       = rand_next();
    b       = rand_next();
    s.sign  = a[31];
    s.exp   = 10'(a[7:0] % 8'd254) + 10'd1;
    s.shr   = (b[25:23] == 3'd0) ? b[31:26] : 6'd0;
    s.fract = {1'b1, a[30:8], b[1:0]};
    return s;
  endfunction

  // the idle producer sees inverted data so a wrong mux shows up
  task automatic present_op(input logic use_mul, input rnd_pkg::rnd_src_t src,
                            input rnd_pkg::rnd_spec_t spec, input logic sub_zero);
    issue_mark     = accept_cnt;
    add_rdy_i      = !use_mul;
    mul_rdy_i      = use_mul;
    add_src_i      = use_mul ? ~src : src;
    mul_src_i      = use_mul ? src : ~src;
    add_sub_zero_i = sub_zero & !use_mul;
    spec_i         = spec;
  endtask

  task automatic wait_taken();
    do begin
      next_cycle();
    end while (accept_cnt == issue_mark);
  endtask

  task automatic issue_op(input logic use_mul, input rnd_pkg::rnd_src_t src,
                          input rnd_pkg::rnd_spec_t spec, input logic sub_zero);
    present_op(use_mul, src, spec, sub_zero);
    wait_taken();
  endtask

  task automatic idle_producers();
    add_rdy_i      = 1'b0;
    mul_rdy_i      = 1'b0;
    add_sub_zero_i = 1'b0;
  endtask

  // grant every cycle until every expected result is out
  task automatic drain();
    idle_producers();
    grant_random = 1'b0;
    grant_i      = 1'b1;
    padv_wrbk_i  = 1'b1;
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////
  // monitor, 2 ns after the falling edge
  ////////////////////////////////////////////////////////////////////

  initial begin : monitor
    expect_t e;
    logic    clear_due;
    clear_due = 1'b0;
    forever begin
      @(negedge cpu_clk);
      #2;
      if (rst_n_i) begin
        // write-back slot owned by another unit at the last rising edge
        if (clear_due) begin
          check_value("res_cleared", 32'd0, res_o);
        end
        clear_due = padv_wrbk_i && !grant_i;
        // write-back loaded at the last rising edge
        if (flags_we_o) begin
          if (exp_q.size() == 0) begin
            report_error("write-back pulse with no result expected");
          end else begin
            e = exp_q.pop_front();
            check_value("res", e.res, res_o);
            check_value("flags", 32'(e.flags), 32'(flags_o));
            check_value("wrbk_except", 32'(except_en_i & (|e.flags)), 32'(wrbk_except_o));
          end
        end
        // oldest result is the one on offer
        if (valid_o && grant_i && exp_q.size() > 0) begin
          check_value("exec_except", 32'(except_en_i & (|exp_q[0].flags)),
                      32'(exec_except_o));
        end
        if (add_taking_o || mul_taking_o) begin
          if (exp_q.size() >= 5) begin
            report_error("taking strobe high with five results in flight");
          end
          exp_q.push_back(model_result(add_rdy_i ? add_src_i : mul_src_i,
                                       add_rdy_i & add_sub_zero_i, spec_i, rm_i, mask_i));
          accept_cnt++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////

  task automatic run_random_modes();
    int          cycles;
    logic [31:0] r;
    test_name   = "random_modes";
    mask_i      = '1;
    except_en_i = 1'b0;
    for (int m = 0; m < 4; m++) begin
      rm_i = rnd_pkg::rnd_mode_e'(2'(m));
      // lone operand, count edges to valid
      issue_op(1'b0, rand_src(), '0, 1'b0);
      idle_producers();
      cycles = 1;
      while (!valid_o && cycles < 10) begin
        next_cycle();
        cycles++;
      end
      check_value("latency", 32'd4, 32'(cycles));
      for (int i = 0; i < N_RAND; i++) begin
        r = rand_next();
        issue_op(r[0], rand_src(), '0, 1'b0);
      end
      drain();
    end
  endtask

  task automatic run_overflow();
    rnd_pkg::rnd_src_t  src;
    rnd_pkg::rnd_spec_t spec;
    logic [31:0]        r;
    test_name   = "overflow";
    rm_i        = rnd_pkg::RND_NEAREST;
    except_en_i = 1'b0;
    for (int p = 0; p < 2; p++) begin
      // second pass hides ovf, ine and inf
      mask_i = (p == 0) ? rnd_pkg::rnd_flags_t'(8'hff) : rnd_pkg::rnd_flags_t'(8'h7a);
      for (int i = 0; i < N_SMALL; i++) begin
        src  = rand_src();
        spec = '0;
        r    = rand_next();
        case (i)
          0: src.exp = 10'd255;
          1: begin
            // all ones, rounds up and carries into 255
            src.exp   = 10'd254;
            src.shr   = 6'd0;
            src.fract = '1;
          end
          2: src.exp = 10'd300;
          3: spec.inf = 1'b1;
          default: src.exp = 10'd253 + 10'(r[1:0]);
        endcase
        issue_op(r[4], src, spec, 1'b0);
      end
      drain();
    end
  endtask

  task automatic run_denormal();
    rnd_pkg::rnd_src_t src;
    logic [31:0]       r;
    test_name   = "denormal";
    mask_i      = '1;
    except_en_i = 1'b0;
    for (int m = 0; m < 4; m++) begin
      rm_i = rnd_pkg::rnd_mode_e'(2'(m));
      for (int i = 0; i < N_SMALL; i++) begin
        src           = rand_src();
        r             = rand_next();
        src.fract[25] = 1'b0;
        if (r[2:0] == 3'd0) begin
          src.fract = '0;
        end
        issue_op(r[4], src, '0, 1'b0);
      end
      // exact zero from an adder subtraction
      src       = rand_src();
      src.exp   = '0;
      src.fract = '0;
      issue_op(1'b0, src, '0, 1'b1);
      drain();
    end
  endtask

  task automatic run_specials();
    rnd_pkg::rnd_src_t  src;
    rnd_pkg::rnd_spec_t spec;
    logic [31:0]        r;
    test_name   = "specials";
    rm_i        = rnd_pkg::RND_NEAREST;
    except_en_i = 1'b1;
    for (int p = 0; p < 2; p++) begin
      mask_i = (p == 0) ? rnd_pkg::rnd_flags_t'(8'hff) : rnd_pkg::rnd_flags_t'(8'h0f);
      for (int i = 0; i < N_SMALL; i++) begin
        src  = rand_src();
        r    = rand_next();
        spec = '0;
        case (r[1:0])
          2'd0:    spec.inv = 1'b1;
          2'd1:    spec.snan = 1'b1;
          2'd2:    spec.qnan = 1'b1;
          default: spec.inf = 1'b1;
        endcase
        spec.anan_sign = r[2];
        issue_op(r[3], src, spec, 1'b0);
      end
      drain();
    end
    except_en_i = 1'b0;
  endtask

  task automatic run_backpressure();
    logic [31:0] r;
    test_name = "backpressure";
    rm_i      = rnd_pkg::RND_NEAREST;
    mask_i    = '1;
    grant_i   = 1'b0;
    // four stages plus the miss buffer
    for (int i = 0; i < 5; i++) begin
      r = rand_next();
      issue_op(r[0], rand_src(), '0, 1'b0);
    end
    // a sixth operand must wait
    present_op(1'b1, rand_src(), '0, 1'b0);
    repeat (4) begin
      next_cycle();
      check_value("taking_full", 32'd0, 32'(add_taking_o | mul_taking_o));
    end
    grant_random = 1'b1;
    stretch      = 0;
    wait_taken();
    for (int i = 6; i < N_STALL; i++) begin
      r = rand_next();
      issue_op(r[0], rand_src(), '0, 1'b0);
    end
    drain();
  endtask

  task automatic run_flush();
    logic [31:0] r;
    test_name = "flush";
    rm_i      = rnd_pkg::RND_NEAREST;
    mask_i    = '1;
    grant_i   = 1'b0;
    for (int i = 0; i < 3; i++) begin
      issue_op(1'b0, rand_src(), '0, 1'b0);
    end
    idle_producers();
    repeat (6) next_cycle();
    check_value("valid_before_flush", 32'd1, 32'(valid_o));
    // stuck results are discarded
    pipeline_flush_i = 1'b1;
    exp_q.delete();
    next_cycle();
    pipeline_flush_i = 1'b0;
    grant_i          = 1'b1;
    repeat (12) next_cycle();
    check_value("valid_after_flush", 32'd0, 32'(valid_o));
    for (int i = 0; i < N_SMALL; i++) begin
      r = rand_next();
      issue_op(r[0], rand_src(), '0, 1'b0);
    end
    drain();
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin : main
    rst_n_i          = 1'b0;
    pipeline_flush_i = 1'b0;
    add_rdy_i        = 1'b0;
    add_src_i        = '0;
    add_sub_zero_i   = 1'b0;
    mul_rdy_i        = 1'b0;
    mul_src_i        = '0;
    spec_i           = '0;
    rm_i             = rnd_pkg::RND_NEAREST;
    mask_i           = '1;
    except_en_i      = 1'b0;
    padv_wrbk_i      = 1'b1;
    grant_i          = 1'b1;
    repeat (4) @(negedge cpu_clk);
    rst_n_i = 1'b1;
    next_cycle();
    run_random_modes();
    run_overflow();
    run_denormal();
    run_specials();
    run_backpressure();
    run_flush();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (MAX_CYCLES) @(posedge cpu_clk);
    $display("Error in %s: run did not finish within %0d cycles", test_name, MAX_CYCLES);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
source/rnd_pkg.sv
source/rnd_capture.sv
source/rnd_align.sv
source/rnd_round.sv
source/rnd_wrbk.sv
source/rnd_top.sv
dv/rnd_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= rnd_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
